//--- Makefile
# Verilator build and run for the HyperBus RAM control block

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tbHbusTop
FILELIST  = sim.f
OBJDIR    = obj_dir
LOG       = sim.log
BIN       = $(OBJDIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# The run passes only if the log holds the pass line
run: compile
	./$(BIN) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- sim.f
src/hbusPkg.sv
src/axiLiteSlave.sv
src/hbusCsr.sv
src/hbusSequencer.sv
src/hbusTop.sv
testbench/hbusRamModel.sv
testbench/hbusTop_sva.sv
testbench/tbHbusTop.sv

//--- src/axiLiteSlave.sv
/*
 * AXI4-Lite slave front end. Turns channel handshakes into one-cycle
 * register write and read strobes for the CSR block, decodes the block
 * select and returns zero for foreign or unknown accesses.
 */
`timescale 1ns/1ps
`default_nettype none

module axiLiteSlave #(
	parameter int         pAxiAdrsWidth = 16,
	parameter logic [7:0] pBlockBase    = 8'h01,
	parameter int         pCsrAdrsWidth = 8
)(
	input  wire                       iSCLK,
	input  wire                       iSRST,
	// Write address / data / response
	input  wire  [pAxiAdrsWidth-1:0]  sAxiAwAddr,
	input  wire                       sAxiAwValid,
	output logic                      sAxiAwReady,
	input  wire  [31:0]               sAxiWData,
	input  wire  [3:0]                sAxiWStrb,
	input  wire                       sAxiWValid,
	output logic                      sAxiWReady,
	output logic [1:0]                sAxiBResp,
	output logic                      sAxiBValid,
	input  wire                       sAxiBReady,
	// Read address / data
	input  wire  [pAxiAdrsWidth-1:0]  sAxiArAddr,
	input  wire                       sAxiArValid,
	output logic                      sAxiArReady,
	output logic [31:0]               sAxiRData,
	output logic [1:0]                sAxiRResp,
	output logic                      sAxiRValid,
	input  wire                       sAxiRReady,
	// Register strobe side
	output logic                      regWe,
	output logic                      regRe,
	output logic [pCsrAdrsWidth-1:0]  regAdrs,
	output logic [31:0]               regWData,
	input  wire  [31:0]               regRData
);

	logic awHit;
	logic arHit;
	logic wrStart;
	logic rdStage;
	logic rdHit;

	// Block select sits in the top byte of the address
	assign awHit   = (sAxiAwAddr[pAxiAdrsWidth-1 -: 8] == pBlockBase);
	assign arHit   = (sAxiArAddr[pAxiAdrsWidth-1 -: 8] == pBlockBase);
	assign wrStart = sAxiAwValid && sAxiWValid && !sAxiAwReady && !sAxiBValid;

	// Write channel --------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			sAxiAwReady <= 1'b0;
			sAxiWReady  <= 1'b0;
			sAxiBValid  <= 1'b0;
			regWe       <= 1'b0;
		end
		else
		begin
			regWe <= 1'b0;
			if (wrStart)
			begin
				sAxiAwReady <= 1'b1;
				sAxiWReady  <= 1'b1;
			end
			else if (sAxiAwReady)
			begin
				sAxiAwReady <= 1'b0;
				sAxiWReady  <= 1'b0;
				if (sAxiAwValid && sAxiWValid)
				begin
					sAxiBValid <= 1'b1;
					// Partial strobes complete but write nothing
					regWe <= awHit && (&sAxiWStrb);
				end
			end
			if (sAxiBValid && sAxiBReady)
				sAxiBValid <= 1'b0;
		end
	end

	// Read channel --------------------
	// ArReady also drops while a write is being accepted, so the
	// shared offset never carries two strobes at once
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			sAxiArReady <= 1'b0;
			sAxiRValid  <= 1'b0;
			regRe       <= 1'b0;
			rdStage     <= 1'b0;
		end
		else
		begin
			regRe   <= 1'b0;
			rdStage <= 1'b0;
			if (sAxiArReady && sAxiArValid)
			begin
				sAxiArReady <= 1'b0;
				regRe       <= arHit;
				rdStage     <= 1'b1;
			end
			else if (wrStart)
				sAxiArReady <= 1'b0;
			else if (!sAxiArReady && !rdStage && !sAxiRValid && !sAxiAwReady)
				sAxiArReady <= 1'b1;
			if (rdStage)
				sAxiRValid <= 1'b1;
			if (sAxiRValid && sAxiRReady)
				sAxiRValid <= 1'b0;
		end
	end

	// Offset and payload capture, low address byte is the word offset
	always_ff @(posedge iSCLK)
	begin
		if (sAxiAwReady && sAxiAwValid && sAxiWValid)
		begin
			regAdrs  <= sAxiAwAddr[pCsrAdrsWidth-1:0];
			regWData <= sAxiWData;
		end
		else if (sAxiArReady && sAxiArValid)
		begin
			regAdrs <= sAxiArAddr[pCsrAdrsWidth-1:0];
			rdHit   <= arHit;
		end
	end

	assign sAxiRData = rdHit ? regRData : 32'd0;
	assign sAxiBResp = 2'b00;
	assign sAxiRResp = 2'b00;

endmodule

`default_nettype wire

//--- src/hbusCsr.sv
/*
 * Control/status registers of the RAM sequencer.
 * Decodes register write strobes, clears the enable on sequence done,
 * captures read-back data and serves registered reads.
 */
`timescale 1ns/1ps
`default_nettype none

module hbusCsr import hbusPkg::*; #(
	parameter int pCsrAdrsWidth = 8
)(
	input  wire                       iSCLK,
	input  wire                       iSRST,
	// Register strobe side
	input  wire                       regWe,
	input  wire                       regRe,
	input  wire  [pCsrAdrsWidth-1:0]  regAdrs,
	input  wire  [31:0]               regWData,
	output logic [31:0]               regRData,
	// Sequencer side
	output logic                      ramRst,
	output logic                      seqEn,
	output hbusCaWord                 caWord,
	output logic [15:0]               wData,
	output logic [3:0]                latencyCnt,
	input  wire                       seqDone,
	input  wire  [15:0]               capData
);

	// Mirror of software's direction bit, direction itself comes from caWord
	logic        seqRwFlag;
	logic [15:0] capWord;

	// Register writes --------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			ramRst     <= 1'b1;
			seqEn      <= 1'b0;
			seqRwFlag  <= 1'b0;
			wData      <= 16'd0;
			caWord.raw <= 48'd0;
			latencyCnt <= 4'd0;
			capWord    <= 16'd0;
		end
		else
		begin
			if (regWe)
			begin
				case (regAdrs)
					pCsrAdrsWidth'(cCsrRamRst):  ramRst <= regWData[0];
					pCsrAdrsWidth'(cCsrSeqCtrl):
					begin
						seqEn     <= regWData[0];
						seqRwFlag <= regWData[4];
					end
					pCsrAdrsWidth'(cCsrWData):   wData <= regWData[15:0];
					pCsrAdrsWidth'(cCsrCaLow):   caWord.raw[31:0] <= regWData;
					pCsrAdrsWidth'(cCsrCaHigh):  caWord.raw[47:32] <= regWData[15:0];
					pCsrAdrsWidth'(cCsrLatency): latencyCnt <= regWData[3:0];
					default: ;
				endcase
			end
			// Done wins over a software write in the same cycle
			if (seqDone)
			begin
				seqEn   <= 1'b0;
				capWord <= capData;
			end
		end
	end

	// Register reads --------------------
	always_ff @(posedge iSCLK)
	begin
		if (regRe)
		begin
			case (regAdrs)
				pCsrAdrsWidth'(cCsrRamRst):  regRData <= {31'd0, ramRst};
				pCsrAdrsWidth'(cCsrSeqCtrl): regRData <= {27'd0, seqRwFlag, 3'd0, seqEn};
				pCsrAdrsWidth'(cCsrWData):   regRData <= {16'd0, wData};
				pCsrAdrsWidth'(cCsrCaLow):   regRData <= caWord.raw[31:0];
				pCsrAdrsWidth'(cCsrCaHigh):  regRData <= {16'd0, caWord.raw[47:32]};
				pCsrAdrsWidth'(cCsrLatency): regRData <= {28'd0, latencyCnt};
				pCsrAdrsWidth'(cCsrCapData): regRData <= {16'd0, capWord};
				// Unknown offsets read as zero
				default:                     regRData <= 32'd0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/hbusPkg.sv
/*
 * Shared definitions for the HyperBus RAM control block.
 * Register word offsets, the command/address word layout and the
 * sequencer state encoding. Modules take it by wildcard import.
 */
`default_nettype none

package hbusPkg;

	// Register word offsets --------------------
	localparam logic [7:0] cCsrRamRst  = 8'h00;
	localparam logic [7:0] cCsrSeqCtrl = 8'h01;
	localparam logic [7:0] cCsrWData   = 8'h02;
	localparam logic [7:0] cCsrCaLow   = 8'h03;
	localparam logic [7:0] cCsrCaHigh  = 8'h04;
	localparam logic [7:0] cCsrLatency = 8'h05;
	localparam logic [7:0] cCsrCapData = 8'h41;

	// Command/address bytes per transaction
	localparam int cCaBytes = 6;

	// Field view of the 48-bit CA word, MSB first
	typedef struct packed {
		logic        rw;
		logic        addrSpace;
		logic        burstLinear;
		logic [28:0] rowColHigh;
		logic [12:0] reserved;
		logic [2:0]  colLow;
	} hbusCaFields;

	typedef union packed {
		logic [47:0] raw;
		hbusCaFields fields;
	} hbusCaWord;

	typedef enum logic [2:0] {idle, cmdAdrs, latency, data, finish} hbusSeqState;

endpackage

`default_nettype wire

//--- src/hbusSequencer.sv
/*
 * Bus sequencer for one RAM access. Shifts the six CA bytes out,
 * waits the programmed latency, then writes or reads one 16-bit word.
 * Started by seqEn, finished with a one-cycle seqDone pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module hbusSequencer import hbusPkg::*; (
	input  wire          iSCLK,
	input  wire          iSRST,
	// From the register block
	input  wire          seqEn,
	input  hbusCaWord    caWord,
	input  wire  [15:0]  wData,
	input  wire  [3:0]   latencyCnt,
	output logic         seqDone,
	output logic [15:0]  capData,
	// Bus pins
	output logic         hbCsN,
	output logic         hbClkEn,
	output logic [7:0]   hbDqOut,
	output logic         hbDqOe,
	input  wire  [7:0]   hbDqIn
);

	localparam int cShiftWidth = cCaBytes * 8;
	localparam int cCntWidth   = $clog2(cCaBytes + 1);

	hbusSeqState           state;
	logic [cCntWidth-1:0]  byteCnt;
	logic [3:0]            latCnt;
	logic                  isRead;
	logic [cShiftWidth-1:0] caShift;
	logic [15:0]           wordReg;
	logic                  start;
	logic                  caDone;
	logic                  enterData;

	assign start     = (state == idle) && seqEn;
	assign caDone    = (state == cmdAdrs) && (byteCnt == cCntWidth'(cCaBytes));
	// Data phase follows the last CA byte or the last latency cycle
	assign enterData = (caDone && latCnt == 4'd0) || ((state == latency) && latCnt == 4'd1);

	// Control FSM --------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state   <= idle;
			byteCnt <= '0;
			latCnt  <= 4'd0;
			isRead  <= 1'b0;
			hbCsN   <= 1'b1;
			hbClkEn <= 1'b0;
			hbDqOe  <= 1'b0;
			seqDone <= 1'b0;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (seqEn)
					begin
						// Chip select leads the first CA byte by one cycle
						state   <= cmdAdrs;
						hbCsN   <= 1'b0;
						byteCnt <= '0;
						latCnt  <= latencyCnt;
						isRead  <= caWord.fields.rw;
					end
				end
				cmdAdrs:
				begin
					if (!caDone)
					begin
						byteCnt <= byteCnt + 1'b1;
						hbClkEn <= 1'b1;
					end
					else if (latCnt != 4'd0)
					begin
						state   <= latency;
						hbClkEn <= 1'b0;
					end
				end
				latency:
					latCnt <= latCnt - 1'b1;
				data:
				begin
					if (byteCnt == '0)
						byteCnt <= cCntWidth'(1);
					else
					begin
						state   <= finish;
						hbCsN   <= 1'b1;
						hbClkEn <= 1'b0;
						hbDqOe  <= 1'b0;
						seqDone <= 1'b1;
					end
				end
				finish:
				begin
					seqDone <= 1'b0;
					state   <= idle;
				end
				default:
					state <= idle;
			endcase
			if (enterData)
			begin
				state   <= data;
				hbClkEn <= 1'b1;
				hbDqOe  <= !isRead;
				byteCnt <= '0;
			end
		end
	end

	// Byte datapath --------------------
	always_ff @(posedge iSCLK)
	begin
		if (start)
		begin
			caShift <= caWord.raw;
			wordReg <= wData;
		end
		else if ((state == cmdAdrs) && !caDone)
		begin
			hbDqOut <= caShift[cShiftWidth-1 -: 8];
			caShift <= caShift << 8;
		end
		// High byte first on the data phase
		if (enterData)
			hbDqOut <= wordReg[15:8];
		if (state == data)
		begin
			hbDqOut <= wordReg[7:0];
			if (isRead)
				capData <= {capData[7:0], hbDqIn};
		end
	end

endmodule

`default_nettype wire

//--- src/hbusTop.sv
/*
 * Top level of the HyperBus RAM control block.
 * AXI4-Lite slave, register block and bus sequencer wired together.
 */
`timescale 1ns/1ps
`default_nettype none

module hbusTop import hbusPkg::*; #(
	parameter int         pAxiAdrsWidth = 16,
	parameter logic [7:0] pBlockBase    = 8'h01,
	parameter int         pCsrAdrsWidth = 8
)(
	input  wire                       iSCLK,
	input  wire                       iSRST,
	// AXI4-Lite slave
	input  wire  [pAxiAdrsWidth-1:0]  sAxiAwAddr,
	input  wire                       sAxiAwValid,
	output logic                      sAxiAwReady,
	input  wire  [31:0]               sAxiWData,
	input  wire  [3:0]                sAxiWStrb,
	input  wire                       sAxiWValid,
	output logic                      sAxiWReady,
	output logic [1:0]                sAxiBResp,
	output logic                      sAxiBValid,
	input  wire                       sAxiBReady,
	input  wire  [pAxiAdrsWidth-1:0]  sAxiArAddr,
	input  wire                       sAxiArValid,
	output logic                      sAxiArReady,
	output logic [31:0]               sAxiRData,
	output logic [1:0]                sAxiRResp,
	output logic                      sAxiRValid,
	input  wire                       sAxiRReady,
	// RAM bus
	output logic                      hbCsN,
	output logic                      hbClkEn,
	output logic [7:0]                hbDqOut,
	output logic                      hbDqOe,
	input  wire  [7:0]                hbDqIn,
	output logic                      ramRst
);

	// Register strobes
	logic                      regWe;
	logic                      regRe;
	logic [pCsrAdrsWidth-1:0]  regAdrs;
	logic [31:0]               regWData;
	logic [31:0]               regRData;

	// Register block to sequencer
	logic       seqEn;
	hbusCaWord  caWord;
	logic [15:0] wData;
	logic [3:0] latencyCnt;
	logic       seqDone;
	logic [15:0] capData;

	axiLiteSlave #(
		.pAxiAdrsWidth (pAxiAdrsWidth),
		.pBlockBase    (pBlockBase),
		.pCsrAdrsWidth (pCsrAdrsWidth)
	) axiSlave (
		.iSCLK, .iSRST,
		.sAxiAwAddr, .sAxiAwValid, .sAxiAwReady,
		.sAxiWData, .sAxiWStrb, .sAxiWValid, .sAxiWReady,
		.sAxiBResp, .sAxiBValid, .sAxiBReady,
		.sAxiArAddr, .sAxiArValid, .sAxiArReady,
		.sAxiRData, .sAxiRResp, .sAxiRValid, .sAxiRReady,
		.regWe, .regRe, .regAdrs, .regWData, .regRData
	);

	hbusCsr #(
		.pCsrAdrsWidth (pCsrAdrsWidth)
	) csr (
		.iSCLK, .iSRST,
		.regWe, .regRe, .regAdrs, .regWData, .regRData,
		.ramRst, .seqEn, .caWord, .wData, .latencyCnt,
		.seqDone, .capData
	);

	hbusSequencer seq (
		.iSCLK, .iSRST,
		.seqEn, .caWord, .wData, .latencyCnt,
		.seqDone, .capData,
		.hbCsN, .hbClkEn, .hbDqOut, .hbDqOe, .hbDqIn
	);

endmodule

`default_nettype wire

//--- testbench/hbusRamModel.sv
/*
 * Behavioral byte-wide RAM on the sequencer bus pins.
 * Collects the CA bytes, counts the latency gap and then stores or
 * returns one 16-bit word. Words live in an associative array by address.
 */
`timescale 1ns/1ps
`default_nettype none

module hbusRamModel import hbusPkg::*; (
	input  wire        iSCLK,
	input  wire        hbCsN,
	input  wire        hbClkEn,
	input  wire  [7:0] hbDqOut,
	input  wire        hbDqOe,
	output logic [7:0] hbDqIn
);

	logic [15:0] mem [logic [31:0]];
	hbusCaWord   ca;
	int          byteIdx;
	int          latCycles;
	logic [31:0] key;
	logic [7:0]  highByte;

	initial
	begin
		hbDqIn    = 8'd0;
		byteIdx   = 0;
		latCycles = 0;
		ca.raw    = 48'd0;
	end

	// Bus sampled mid-cycle, away from the DUT clock edge
	always @(negedge iSCLK)
	begin
		if (hbCsN)
			byteIdx = 0;
		else if (!hbClkEn)
		begin
			// Latency gap between CA and data
			if (byteIdx == cCaBytes)
				latCycles++;
		end
		else if (byteIdx < cCaBytes)
		begin
			if (byteIdx == 0)
				latCycles = 0;
			ca.raw = {ca.raw[39:0], hbDqOut};
			byteIdx++;
			if (byteIdx == cCaBytes)
			begin
				key = {ca.fields.rowColHigh, ca.fields.colLow};
				// High byte waits on the pins through the gap
				if (ca.fields.rw)
					hbDqIn = mem.exists(key) ? mem[key][15:8] : 8'd0;
			end
		end
		else if (byteIdx == cCaBytes)
		begin
			if (!ca.fields.rw && hbDqOe)
				highByte = hbDqOut;
			byteIdx++;
		end
		else
		begin
			if (!ca.fields.rw && hbDqOe)
				mem[key] = {highByte, hbDqOut};
			else if (ca.fields.rw)
				hbDqIn = mem.exists(key) ? mem[key][7:0] : 8'd0;
			byteIdx++;
		end
	end

endmodule

`default_nettype wire

//--- testbench/hbusTop_sva.sv
/*
 * Protocol assertions bound into the top level.
 * AXI response hold under back-pressure and the chip-select rules.
 */
`timescale 1ns/1ps
`default_nettype none

module hbusTop_sva (
	input wire        iSCLK,
	input wire        iSRST,
	input wire        sAxiBValid,
	input wire        sAxiBReady,
	input wire        sAxiRValid,
	input wire        sAxiRReady,
	input wire [31:0] sAxiRData,
	input wire        hbCsN,
	input wire        hbClkEn,
	input wire        hbDqOe,
	input wire        seqDone
);

	// Responses hold until taken --------------------
	bValidHold: assert property (@(posedge iSCLK) disable iff (iSRST)
		sAxiBValid && !sAxiBReady |=> sAxiBValid)
		else $error("BVALID dropped before BREADY");

	rValidHold: assert property (@(posedge iSCLK) disable iff (iSRST)
		sAxiRValid && !sAxiRReady |=> sAxiRValid && $stable(sAxiRData))
		else $error("RVALID or RDATA changed before RREADY");

	// Bus rules --------------------
	busQuiet: assert property (@(posedge iSCLK) disable iff (iSRST)
		hbCsN |-> !hbClkEn && !hbDqOe)
		else $error("clock enable or output enable active while deselected");

	doneAtDeselect: assert property (@(posedge iSCLK) disable iff (iSRST)
		seqDone == $rose(hbCsN))
		else $error("seqDone not aligned with chip select rising");

endmodule

`default_nettype wire

//--- testbench/tbHbusTop.sv
/*
 * Testbench for the HyperBus RAM control block. Drives the AXI4-Lite
 * port on the falling edge, runs register and RAM command tests against
 * a behavioral RAM, prints one line per test and a closing summary.
 */
`timescale 1ns/1ps
`default_nettype none

module tbHbusTop import hbusPkg::*; ();

	localparam logic [7:0] cBlock      = 8'h01;
	localparam logic [7:0] cOtherBlock = 8'h02;
	localparam int         cWaitLimit  = 40;
	localparam int         cPollLimit  = 50;

	logic        iSCLK;
	logic        iSRST;
	logic [15:0] sAxiAwAddr;
	logic        sAxiAwValid;
	logic        sAxiAwReady;
	logic [31:0] sAxiWData;
	logic [3:0]  sAxiWStrb;
	logic        sAxiWValid;
	logic        sAxiWReady;
	logic [1:0]  sAxiBResp;
	logic        sAxiBValid;
	logic        sAxiBReady;
	logic [15:0] sAxiArAddr;
	logic        sAxiArValid;
	logic        sAxiArReady;
	logic [31:0] sAxiRData;
	logic [1:0]  sAxiRResp;
	logic        sAxiRValid;
	logic        sAxiRReady;
	logic        hbCsN;
	logic        hbClkEn;
	logic [7:0]  hbDqOut;
	logic        hbDqOe;
	logic [7:0]  hbDqIn;
	logic        ramRst;

	int          seed;
	int          cycleCnt = 0;
	int          errorCount;
	int          testErrStart;
	int          passCount;
	int          failCount;
	int          enBValidCycle;
	int          csRiseCycle;
	logic        prevCsN;
	logic [31:0] shadow [0:5];
	logic        capValid;
	logic [31:0] capKey;
	logic [31:0] gotQ [$];
	logic [31:0] expQ [$];
	string       msgQ [$];
	event        resultReady;

	hbusTop #(.pBlockBase(cBlock)) DUT (.*);

	hbusRamModel ramModel (.iSCLK, .hbCsN, .hbClkEn, .hbDqOut, .hbDqOe, .hbDqIn);

	bind hbusTop hbusTop_sva protocolCheck (
		.iSCLK, .iSRST, .sAxiBValid, .sAxiBReady, .sAxiRValid, .sAxiRReady,
		.sAxiRData, .hbCsN, .hbClkEn, .hbDqOe, .seqDone
	);

	initial
	begin
		iSCLK = 1'b0;
		forever #50 iSCLK = ~iSCLK;
	end

	always @(posedge iSCLK)
		cycleCnt <= cycleCnt + 1;

	// Remember the cycle of the last chip select release
	always @(negedge iSCLK)
	begin
		if (hbCsN === 1'b1 && prevCsN === 1'b0)
			csRiseCycle = cycleCnt;
		prevCsN = hbCsN;
	end

	// Checking --------------------
	task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp)
		begin
			errorCount++;
			$display("ERROR at time %0d ns: %s, got 0x%08h, expected 0x%08h",
				$time, msg, got, exp);
		end
	endtask

	task automatic timeoutFail(input string msg);
		errorCount++;
		$display("Timeout at time %0d ns: %s", $time, msg);
	endtask

	task automatic queueResult(input logic [31:0] got, input logic [31:0] exp, input string msg);
		gotQ.push_back(got);
		expQ.push_back(exp);
		msgQ.push_back(msg);
		-> resultReady;
	endtask

	initial
	begin
		forever
		begin
			@(resultReady);
			while (gotQ.size() > 0)
				checkValue(gotQ.pop_front(), expQ.pop_front(), msgQ.pop_front());
		end
	end

	// Register view from everything software wrote
	function automatic logic [31:0] expectedRead(input logic [7:0] offset);
		logic [31:0] value;
		value = 32'd0;
		case (offset)
			cCsrRamRst:  value = shadow[0] & 32'h1;
			cCsrSeqCtrl: value = shadow[1] & 32'h11;
			cCsrWData:   value = shadow[2] & 32'hFFFF;
			cCsrCaLow:   value = shadow[3];
			cCsrCaHigh:  value = shadow[4] & 32'hFFFF;
			cCsrLatency: value = shadow[5] & 32'hF;
			cCsrCapData:
				if (capValid)
					value = {16'd0, ramModel.mem[capKey]};
			default:     value = 32'd0;
		endcase
		return value;
	endfunction

	// Enable write to chip-select rise: regWe, seqEn register, start cycle,
	// CA bytes, latency gap and two data bytes
	function automatic int expectedCycles(input logic [3:0] lat);
		return 3 + cCaBytes + int'(lat) + 2;
	endfunction

	// AXI4-Lite tasks --------------------
	task automatic axiWrite(input logic [7:0] block, input logic [7:0] offset,
		input logic [31:0] value);
		int waitCnt;
		sAxiAwAddr  = {block, offset};
		sAxiWData   = value;
		sAxiWStrb   = 4'hF;
		sAxiAwValid = 1'b1;
		sAxiWValid  = 1'b1;
		waitCnt = 0;
		while (!sAxiAwReady && waitCnt < cWaitLimit)
		begin
			@(negedge iSCLK);
			waitCnt++;
		end
		if (!sAxiAwReady)
			timeoutFail("write address and data were never accepted");
		else
			queueResult({31'd0, sAxiWReady}, 32'd1, "WREADY together with AWREADY");
		@(negedge iSCLK);
		sAxiAwValid = 1'b0;
		sAxiWValid  = 1'b0;
		waitCnt = 0;
		while (!sAxiBValid && waitCnt < cWaitLimit)
		begin
			@(negedge iSCLK);
			waitCnt++;
		end
		if (!sAxiBValid)
			timeoutFail("write response never arrived");
		enBValidCycle = cycleCnt;
		queueResult({30'd0, sAxiBResp}, 32'd0, "write response code");
		sAxiBReady = 1'b1;
		@(negedge iSCLK);
		sAxiBReady = 1'b0;
		if (block == cBlock && offset <= 8'd5)
			shadow[offset] = value;
	endtask

	// holdCycles keeps RREADY low that many cycles after RVALID
	task automatic axiRead(input logic [7:0] block, input logic [7:0] offset,
		input int holdCycles, output logic [31:0] value);
		int waitCnt;
		int i;
		logic [31:0] firstData;
		sAxiArAddr  = {block, offset};
		sAxiArValid = 1'b1;
		waitCnt = 0;
		while (!sAxiArReady && waitCnt < cWaitLimit)
		begin
			@(negedge iSCLK);
			waitCnt++;
		end
		if (!sAxiArReady)
			timeoutFail("read address was never accepted");
		@(negedge iSCLK);
		sAxiArValid = 1'b0;
		waitCnt = 0;
		while (!sAxiRValid && waitCnt < cWaitLimit)
		begin
			@(negedge iSCLK);
			waitCnt++;
		end
		if (!sAxiRValid)
			timeoutFail("read data never arrived");
		firstData = sAxiRData;
		for (i = 0; i < holdCycles; i++)
		begin
			@(negedge iSCLK);
			queueResult({31'd0, sAxiRValid}, 32'd1, "RVALID under back-pressure");
			queueResult(sAxiRData, firstData, "RDATA under back-pressure");
		end
		value = sAxiRData;
		queueResult({30'd0, sAxiRResp}, 32'd0, "read response code");
		sAxiRReady = 1'b1;
		@(negedge iSCLK);
		sAxiRReady = 1'b0;
	endtask

	task automatic compareRead(input logic [7:0] offset);
		logic [31:0] got;
		axiRead(cBlock, offset, 0, got);
		queueResult(got, expectedRead(offset), $sformatf("register 0x%02h", offset));
	endtask

	// Program CA, word and latency, start and poll until the enable clears
	task automatic runCommand(input logic rw, input logic [31:0] key, input logic [15:0] word,
		input logic [3:0] lat, output int cycles);
		hbusCaWord   ca;
		logic [31:0] status;
		int          polls;
		int          startCycle;
		ca.raw                = 48'd0;
		ca.fields.rw          = rw;
		ca.fields.burstLinear = 1'b1;
		ca.fields.rowColHigh  = key[31:3];
		ca.fields.colLow      = key[2:0];
		axiWrite(cBlock, cCsrCaLow, ca.raw[31:0]);
		axiWrite(cBlock, cCsrCaHigh, {16'd0, ca.raw[47:32]});
		axiWrite(cBlock, cCsrWData, {16'd0, word});
		axiWrite(cBlock, cCsrLatency, {28'd0, lat});
		axiWrite(cBlock, cCsrSeqCtrl, {27'd0, rw, 3'd0, 1'b1});
		startCycle = enBValidCycle;
		polls  = 0;
		status = 32'd1;
		while (status[0] && polls < cPollLimit)
		begin
			axiRead(cBlock, cCsrSeqCtrl, 0, status);
			polls++;
		end
		if (status[0])
			timeoutFail("sequence enable never cleared");
		shadow[1][0] = 1'b0;
		cycles = csRiseCycle - startCycle;
	endtask

	task automatic finishTest(input string name);
		@(negedge iSCLK);
		if (errorCount == testErrStart)
		begin
			passCount++;
			$display("[pass] %s", name);
		end
		else
		begin
			failCount++;
			$display("[fail] %s, %0d errors", name, errorCount - testErrStart);
		end
		testErrStart = errorCount;
	endtask

	// Test sequence --------------------
	initial
	begin
		logic [31:0] got;
		logic [31:0] value;
		logic [31:0] key;
		logic [15:0] word;
		logic [3:0]  lat;
		int          cycles;
		int          idx;

		seed          = 80677;
		errorCount    = 0;
		testErrStart  = 0;
		passCount     = 0;
		failCount     = 0;
		enBValidCycle = 0;
		csRiseCycle   = 0;
		prevCsN       = 1'b1;
		capValid      = 1'b0;
		capKey        = 32'd0;
		shadow[0]     = 32'd1;
		for (idx = 1; idx <= 5; idx++)
			shadow[idx] = 32'd0;
		iSRST       = 1'b1;
		sAxiAwAddr  = 16'd0;
		sAxiAwValid = 1'b0;
		sAxiWData   = 32'd0;
		sAxiWStrb   = 4'h0;
		sAxiWValid  = 1'b0;
		sAxiBReady  = 1'b0;
		sAxiArAddr  = 16'd0;
		sAxiArValid = 1'b0;
		sAxiRReady  = 1'b0;
		repeat (4) @(negedge iSCLK);
		queueResult({29'd0, sAxiAwReady, sAxiWReady, sAxiArReady}, 32'd0,
			"ready signals during reset");
		iSRST = 1'b0;
		@(negedge iSCLK);

		// 1. Reset state
		queueResult({31'd0, sAxiBValid}, 32'd0, "BVALID after reset");
		queueResult({31'd0, sAxiRValid}, 32'd0, "RVALID after reset");
		queueResult({31'd0, hbCsN}, 32'd1, "chip select after reset");
		queueResult({31'd0, ramRst}, 32'd1, "RAM reset pin after reset");
		for (idx = 0; idx <= 5; idx++)
			compareRead(8'(idx));
		compareRead(cCsrCapData);
		finishTest("reset state");

		// 2. Register round trip
		for (idx = 0; idx <= 5; idx++)
		begin
			value = $random(seed);
			// Sequencer stays idle
			if (idx == 1)
				value[0] = 1'b0;
			axiWrite(cBlock, 8'(idx), value);
		end
		for (idx = 0; idx <= 5; idx++)
			compareRead(8'(idx));
		finishTest("register round trip");

		// 3. Write command
		axiWrite(cBlock, cCsrRamRst, 32'd0);
		queueResult({31'd0, ramRst}, 32'd0, "RAM reset pin released");
		key   = $random(seed);
		value = $random(seed);
		word  = value[15:0];
		lat   = {1'b0, value[18:16]} + 4'd1;
		runCommand(1'b0, key, word, lat, cycles);
		queueResult(ramModel.mem.exists(key) ? 32'd1 : 32'd0, 32'd1, "RAM word present");
		queueResult({16'd0, ramModel.mem[key]}, {16'd0, word}, "RAM word after write");
		compareRead(cCsrSeqCtrl);
		finishTest("write command");

		// 4. Read command, write word differs so only the RAM can answer
		runCommand(1'b1, key, ~word, lat, cycles);
		capValid = 1'b1;
		capKey   = key;
		compareRead(cCsrCapData);
		queueResult({16'd0, ramModel.mem[key]}, {16'd0, word}, "RAM word kept after read");
		finishTest("read command");

		// 5. Timing with no latency and with the longest latency
		value = $random(seed);
		key   = $random(seed);
		runCommand(1'b0, key, value[15:0], 4'd0, cycles);
		queueResult(cycles, expectedCycles(4'd0), "enable to deselect, latency 0");
		queueResult(ramModel.latCycles, 32'd0, "RAM latency gap, latency 0");
		runCommand(1'b1, key, 16'd0, 4'd15, cycles);
		queueResult(cycles, expectedCycles(4'd15), "enable to deselect, latency 15");
		queueResult(ramModel.latCycles, 32'd15, "RAM latency gap, latency 15");
		capKey = key;
		compareRead(cCsrCapData);
		finishTest("command timing");

		// 6. Back-pressure and foreign block
		axiRead(cBlock, cCsrWData, 6, got);
		queueResult(got, expectedRead(cCsrWData), "held read data");
		value = $random(seed);
		axiWrite(cOtherBlock, cCsrWData, value);
		compareRead(cCsrWData);
		axiRead(cOtherBlock, cCsrWData, 0, got);
		queueResult(got, 32'd0, "read from foreign block");
		compareRead(8'h10);
		finishTest("back-pressure and foreign block");

		$display("Summary: %0d tests passed, %0d failed, %0d errors",
			passCount, failCount, errorCount);
		if (errorCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
